/* bt656_insert_top.f */
+incdir+design
design/bt656_pkg.sv
design/video_if.sv
design/trs_decoder.sv
design/stream_delay.sv
design/pn_sequence_gen.sv
design/sequence_switch.sv
design/bt656_insert_top.sv
dv/bt656_insert_chk.sv
dv/bt656_insert_tb.sv

/* Makefile */
TOP := bt656_insert_tb
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f bt656_insert_top.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	! grep -q "Errors found" $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/bt656_insert_tb.sv */
`timescale 1ns/1ps
`include "bt656_settings.svh"

module bt656_insert_tb;

   localparam int TRS_LEN     = 4;
   localparam int BLANK_WORDS = 16;
   localparam int LINE_WORDS  = 2 * TRS_LEN + BLANK_WORDS + `ACTIVE_WORDS;
   localparam int NUM_FRAMES  = 4;
   localparam int MAX_LINES   = 2 + 4;
   localparam int OUT_LATENCY = `DELAY_DEPTH + 1;
   localparam int CLK_PERIOD  = 40;
   localparam int TIMEOUT_NS  = (NUM_FRAMES * MAX_LINES * LINE_WORDS + 1000) * CLK_PERIOD;

   // model states
   localparam int M_WAIT   = 0;
   localparam int M_ARMED  = 1;
   localparam int M_SKIP   = 2;
   localparam int M_INSERT = 3;
   localparam int M_DONE   = 4;

   logic       clk;
   logic       reset_n;
   logic [9:0] stream_in;
   logic [9:0] stream_out;
   logic       v_out;
   logic       f_out;

   integer seed;
   int     error_count;
   int     check_count;

   // flags of the word being sent
   logic cur_f;
   logic cur_v;
   logic cur_h;

   // reference model queue holds {f, v, data}
   logic [11:0] expect_q [$];
   int          m_state;
   int          m_count;
   int          m_tail;
   logic [9:0]  m_lfsr;
   logic        m_prev_h;
   logic        m_prev_v;
   logic        m_hold;

   bt656_insert_top DUT (
      .clk        (clk),
      .reset_n    (reset_n),
      .stream_in  (stream_in),
      .stream_out (stream_out),
      .v_out      (v_out),
      .f_out      (f_out)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // shift left with the tap parity in at bit 0
   function automatic logic [9:0] next_pn(input logic [9:0] value);
      return {value[8:0], ^(value & `PN_TAPS)};
   endfunction

   // XY layout is 1 F V H P3 P2 P1 P0 0 0
   function automatic logic [9:0] xy_word(input logic f, input logic v, input logic h);
      return {1'b1, f, v, h, v ^ h, f ^ h, f ^ v, f ^ v ^ h, 2'b00};
   endfunction

   // payload kept within 004..3FB so no TRS can be faked
   function automatic logic [9:0] random_active();
      int unsigned r;
      r = $unsigned($random(seed));
      return 10'(10'h004 + r % 1016);
   endfunction

   task automatic check_value(input string name, input logic [9:0] expected,
                              input logic [9:0] observed);
      check_count++;
      if (observed !== expected) begin
         error_count++;
         $display("Error: %s expected %h observed %h at %0t ns",
                  name, expected, observed, $time);
      end
   endtask

   task automatic model_word(input logic [9:0] word);
      logic       h_rise;
      logic       h_fall;
      logic       v_rise;
      logic       v_fall;
      logic       exp_v;
      logic [9:0] exp_data;
      h_rise   = cur_h & ~m_prev_h;
      h_fall   = ~cur_h & m_prev_h;
      v_rise   = cur_v & ~m_prev_v;
      v_fall   = ~cur_v & m_prev_v;
      exp_data = word;
      exp_v    = cur_v | m_hold;
      if (cur_v) begin
         m_hold = 1'b1;
      end else if (m_tail > 0) begin
         m_tail--;
         if (m_tail == 0) begin
            m_hold = 1'b0;
         end
      end
      case (m_state)
         M_WAIT: begin
            // EAV of the first active line
            if (h_rise && v_fall) begin
               m_state = M_ARMED;
               m_lfsr  = `PN_SEED;
            end
         end
         M_ARMED: begin
            // SAV starts here and its TRS passes unchanged
            if (h_fall) begin
               m_state = M_SKIP;
               m_count = TRS_LEN - 1;
            end
         end
         M_SKIP: begin
            m_count--;
            if (m_count == 0) begin
               m_state = M_INSERT;
               m_count = `ACTIVE_WORDS;
            end
         end
         M_INSERT: begin
            exp_data = m_lfsr;
            m_lfsr   = next_pn(m_lfsr);
            m_count--;
            if (m_count == 0) begin
               m_state = M_DONE;
               m_tail  = `V_EXTEND;
            end
         end
         default: begin
            if (v_rise) begin
               m_state = M_WAIT;
            end
         end
      endcase
      m_prev_h = cur_h;
      m_prev_v = cur_v;
      expect_q.push_back({cur_f, exp_v, exp_data});
   endtask

   // outputs settle after the rising edge so sample before driving
   task automatic send_word(input logic [9:0] word);
      logic [11:0] expected;
      @(negedge clk);
      expected = expect_q.pop_front();
      check_value("stream_out", expected[9:0], stream_out);
      check_value("v_out", {9'b0, expected[10]}, {9'b0, v_out});
      check_value("f_out", {9'b0, expected[11]}, {9'b0, f_out});
      stream_in = word;
      model_word(word);
   endtask

   task automatic send_trs(input logic f, input logic v, input logic h);
      // new flags travel with the whole TRS including its 3FF
      cur_f = f;
      cur_v = v;
      cur_h = h;
      send_word(10'h3FF);
      send_word(10'h000);
      send_word(10'h000);
      send_word(xy_word(f, v, h));
   endtask

   task automatic send_line(input logic f, input logic v);
      send_trs(f, v, 1'b1);
      for (int i = 0; i < BLANK_WORDS; i++) begin
         send_word(i[0] ? 10'h040 : 10'h200);
      end
      send_trs(f, v, 1'b0);
      for (int i = 0; i < `ACTIVE_WORDS; i++) begin
         send_word(random_active());
      end
   endtask

   initial begin
      int active_lines;
      clk         = 1'b0;
      reset_n     = 1'b0;
      stream_in   = 10'h000;
      seed        = 93;
      error_count = 0;
      check_count = 0;
      cur_f       = 1'b0;
      cur_v       = 1'b0;
      cur_h       = 1'b0;
      m_state     = M_WAIT;
      m_count     = 0;
      m_tail      = 0;
      m_lfsr      = `PN_SEED;
      m_prev_h    = 1'b0;
      m_prev_v    = 1'b0;
      m_hold      = 1'b0;
      repeat (10) begin
         @(negedge clk);
         check_value("stream_out", 10'h000, stream_out);
         check_value("v_out", 10'h000, {9'b0, v_out});
      end
      reset_n = 1'b1;
      // delay line still holds its reset zeros
      repeat (OUT_LATENCY) expect_q.push_back(12'h000);
      for (int frame = 0; frame < NUM_FRAMES; frame++) begin
         active_lines = 2 + ($unsigned($random(seed)) % 3);
         send_line(frame[0], 1'b1);
         send_line(frame[0], 1'b1);
         repeat (active_lines) send_line(frame[0], 1'b0);
      end
      // flush the last real words out
      repeat (OUT_LATENCY) send_word(10'h200);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the frames did not complete within %0d ns", TIMEOUT_NS);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("Errors found");
      $finish;
   end

endmodule

/* dv/bt656_insert_chk.sv */
`timescale 1ns/1ps

module bt656_insert_chk
   import bt656_pkg::*;
(
   input logic          clk,
   input logic          reset_n,
   input switch_state_t state,
   input logic          vid_v,
   input logic          v_out,
   input logic          load_generator,
   input logic          enable_generator
);

   // generator must not step before a frame has been armed
   no_enable_in_wait: assert property (
      @(posedge clk) disable iff (!reset_n)
      (state == WAIT_VBLANK) |-> !enable_generator
   ) else $error("enable_generator is high in WAIT_VBLANK");

   load_only_armed: assert property (
      @(posedge clk) disable iff (!reset_n)
      load_generator |-> (state == ARMED)
   ) else $error("load_generator is high outside ARMED");

   // registered v_out lags blanking and the inserted line by one word
   v_out_covers_v: assert property (
      @(posedge clk) disable iff (!reset_n)
      (vid_v || state == INSERT || state == TAIL) |=> v_out
   ) else $error("v_out is low during vertical blanking or the inserted line");

endmodule

bind sequence_switch bt656_insert_chk u_switch_chk (
   .clk              (clk),
   .reset_n          (reset_n),
   .state            (state),
   .vid_v            (vid.v),
   .v_out            (v_out),
   .load_generator   (load_generator),
   .enable_generator (enable_generator)
);

/* design/bt656_insert_top.sv */
`timescale 1ns/1ps

module bt656_insert_top (
   input  logic       clk,
   input  logic       reset_n,
   input  logic [9:0] stream_in,
   output logic [9:0] stream_out,
   output logic       v_out,
   output logic       f_out
);

   logic       load_generator;
   logic       enable_generator;
   logic [9:0] sequence_word;

   // delayed words plus decoded flags
   video_if dec_vif ();

   // flags side of dec_vif
   trs_decoder u_trs_decoder (
      .clk       (clk),
      .reset_n   (reset_n),
      .stream_in (stream_in),
      .vid       (dec_vif.source)
   );

   // data side of dec_vif
   stream_delay u_stream_delay (
      .clk       (clk),
      .reset_n   (reset_n),
      .stream_in (stream_in),
      .vid       (dec_vif.source)
   );

   pn_sequence_gen u_pn_sequence_gen (
      .clk     (clk),
      .reset_n (reset_n),
      .load    (load_generator),
      .enable  (enable_generator),
      .word    (sequence_word)
   );

   sequence_switch u_sequence_switch (
      .clk              (clk),
      .reset_n          (reset_n),
      .vid              (dec_vif.sink),
      .sequence_word    (sequence_word),
      .stream_out       (stream_out),
      .v_out            (v_out),
      .f_out            (f_out),
      .load_generator   (load_generator),
      .enable_generator (enable_generator)
   );

endmodule

/* design/sequence_switch.sv */
`timescale 1ns/1ps
`include "bt656_settings.svh"

module sequence_switch
   import bt656_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   video_if.sink      vid,
   input  logic [9:0] sequence_word,
   output logic [9:0] stream_out,
   output logic       v_out,
   output logic       f_out,
   output logic       load_generator,
   output logic       enable_generator
);

   localparam int CNT_W = $clog2(`ACTIVE_WORDS);
   localparam logic [CNT_W-1:0] LAST_TRS    = CNT_W'(`DELAY_DEPTH - 1);
   localparam logic [CNT_W-1:0] LAST_ACTIVE = CNT_W'(`ACTIVE_WORDS - 1);
   localparam logic [CNT_W-1:0] LAST_TAIL   = CNT_W'(`V_EXTEND - 1);

   switch_state_t    state;
   logic [CNT_W-1:0] word_cnt;
   logic             prev_h;
   logic             prev_v;
   logic             h_rise;
   logic             h_fall;
   logic             v_rise;
   logic             v_fall;
   logic             v_hold;

   assign h_rise = vid.h & ~prev_h;
   assign h_fall = ~vid.h & prev_h;
   assign v_rise = vid.v & ~prev_v;
   assign v_fall = ~vid.v & prev_v;

   // generator holds the seed while armed, steps once per inserted word
   assign load_generator   = (state == ARMED);
   assign enable_generator = (state == INSERT);

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state    <= WAIT_VBLANK;
         word_cnt <= '0;
         prev_h   <= 1'b0;
         prev_v   <= 1'b0;
      end else begin
         prev_h <= vid.h;
         prev_v <= vid.v;
         case (state)
            WAIT_VBLANK: begin
               // EAV of the first active line
               if (h_rise && v_fall) begin
                  state    <= ARMED;
                  word_cnt <= '0;
               end
            end
            ARMED: begin
               // H falls on the SAV 3FF, skip the rest of the SAV
               if (h_fall || word_cnt != '0) begin
                  if (word_cnt == LAST_TRS) begin
                     state    <= INSERT;
                     word_cnt <= '0;
                  end else begin
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
            end
            INSERT: begin
               if (word_cnt == LAST_ACTIVE) begin
                  state    <= TAIL;
                  word_cnt <= '0;
               end else begin
                  word_cnt <= word_cnt + 1'b1;
               end
            end
            TAIL: begin
               if (word_cnt == LAST_TAIL) begin
                  state    <= DONE;
                  word_cnt <= '0;
               end else begin
                  word_cnt <= word_cnt + 1'b1;
               end
            end
            DONE: begin
               // one insertion per frame
               if (v_rise) begin
                  state <= WAIT_VBLANK;
               end
            end
            default: begin
               state <= WAIT_VBLANK;
            end
         endcase
      end
   end

   // keeps v_out up past the falling V so the rotator leaves the line alone
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         v_hold <= 1'b0;
      end else if (vid.v) begin
         v_hold <= 1'b1;
      end else if (state == TAIL && word_cnt == LAST_TAIL) begin
         v_hold <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         stream_out <= 10'h000;
         v_out      <= 1'b0;
         f_out      <= 1'b0;
      end else begin
         stream_out <= enable_generator ? sequence_word : vid.data;
         v_out      <= vid.v | v_hold;
         f_out      <= vid.f;
      end
   end

endmodule

/* design/pn_sequence_gen.sv */
`timescale 1ns/1ps
`include "bt656_settings.svh"

module pn_sequence_gen (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       load,
   input  logic       enable,
   output logic [9:0] word
);

   logic [9:0] lfsr;
   logic       feedback;

   // parity of the tapped bits
   assign feedback = ^(lfsr & `PN_TAPS);

   // load wins over enable
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         lfsr <= `PN_SEED;
      end else if (load) begin
         lfsr <= `PN_SEED;
      end else if (enable) begin
         lfsr <= {lfsr[8:0], feedback};
      end
   end

   // current word straight from the register
   assign word = lfsr;

endmodule

/* design/stream_delay.sv */
`timescale 1ns/1ps
`include "bt656_settings.svh"

module stream_delay (
   input  logic       clk,
   input  logic       reset_n,
   input  logic [9:0] stream_in,
   video_if.source    vid
);

   // stage 0 takes the newest word
   logic [9:0] stage [`DELAY_DEPTH];

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         for (int i = 0; i < `DELAY_DEPTH; i++) begin
            stage[i] <= 10'h000;
         end
      end else begin
         stage[0] <= stream_in;
         for (int i = 1; i < `DELAY_DEPTH; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   // the decoder sees the whole TRS before the first word of it leaves here,
   // so its flags change together with the delayed preamble
   assign vid.data = stage[`DELAY_DEPTH-1];

endmodule

/* design/trs_decoder.sv */
`timescale 1ns/1ps

module trs_decoder
   import bt656_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  logic [9:0] stream_in,
   video_if.source    vid
);

   trs_state_t state;
   trs_state_t state_next;
   logic       is_ones;
   logic       is_zeros;

   assign is_ones  = (stream_in == 10'h3FF);
   assign is_zeros = (stream_in == 10'h000);

   // preamble match, a stray 3FF restarts it
   always_comb begin
      state_next = IDLE;
      case (state)
         IDLE: begin
            if (is_ones) begin
               state_next = GOT_3FF;
            end
         end
         GOT_3FF: begin
            if (is_zeros) begin
               state_next = GOT_00A;
            end else if (is_ones) begin
               state_next = GOT_3FF;
            end
         end
         GOT_00A: begin
            if (is_zeros) begin
               state_next = GOT_00B;
            end else if (is_ones) begin
               state_next = GOT_3FF;
            end
         end
         GOT_00B: begin
            // this word is XY
            if (is_ones) begin
               state_next = GOT_3FF;
            end
         end
         default: begin
            state_next = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state <= IDLE;
         vid.f <= 1'b0;
         vid.v <= 1'b0;
         vid.h <= 1'b0;
      end else begin
         state <= state_next;
         // XY protection bits are trusted as is
         if (state == GOT_00B) begin
            vid.f <= stream_in[8];
            vid.v <= stream_in[7];
            vid.h <= stream_in[6];
         end
      end
   end

endmodule

/* design/video_if.sv */
`timescale 1ns/1ps

// one bt656 word per clock with its timing flags
interface video_if;
   logic [9:0] data;
   // line blanking, field blanking, field id
   logic       h;
   logic       v;
   logic       f;

   modport source (
      output data,
      output h,
      output v,
      output f
   );

   modport sink (
      input data,
      input h,
      input v,
      input f
   );
endinterface

/* design/bt656_pkg.sv */
package bt656_pkg;

   // position inside the 3FF 000 000 XY preamble
   typedef enum logic [1:0] {
      IDLE,
      GOT_3FF,
      GOT_00A,
      GOT_00B
   } trs_state_t;

   // where the switch is within one frame
   typedef enum logic [2:0] {
      WAIT_VBLANK,
      ARMED,
      INSERT,
      TAIL,
      DONE
   } switch_state_t;

endpackage

/* design/bt656_settings.svh */
`ifndef BT656_SETTINGS_SVH
`define BT656_SETTINGS_SVH

// active words per line, Cb Y Cr Y for 720 pixels
`define ACTIVE_WORDS 1440

// delay line length in words
// flags lead the delayed stream by this lookahead
`define DELAY_DEPTH 4

// lfsr start value, must be nonzero
`define PN_SEED 10'h2A5

// feedback mask for x^10 + x^7 + 1
`define PN_TAPS 10'h240

// words that v_out stays high after the inserted line
`define V_EXTEND 3

`endif
